/* project.f */
design/retire_pkg.sv
design/rob.sv
design/arch_map_table.sv
design/freelist.sv
design/retire_stage.sv
design/retire_top.sv
tb/retire_tb.sv

/* Makefile */
TOP := retire_tb
LOG := sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f project.f -o V$(TOP)

run: build
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || { echo "simulation did not complete"; exit 1; }

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f project.f

clean:
	rm -rf obj_dir $(LOG)

/* tb/retire_tb.sv */
// reference model of rob, map and free list, random stimulus, compare tasks and a watchdog
`timescale 1ns/100ps

module retire_tb import retire_pkg::*; ();

    localparam int n_cycles = 4000;                 // random stimulus cycles
    localparam int period   = 40;

    logic                         clock;
    logic                         rst_n;
    logic                         dispatch_en;
    arch_reg_t                    dispatch_ar;
    phys_reg_t                    dispatch_told;
    logic                         dispatch_precise;
    addr_t                        dispatch_target;
    logic                         complete_en;
    rob_idx_t                     complete_idx;
    rob_idx_t                     dispatch_idx;
    phys_reg_t                    alloc_pr;
    logic                         rob_full;
    logic [retire_width-1:0]      retire_en;
    arch_reg_t [retire_width-1:0] retire_ar;
    phys_reg_t [retire_width-1:0] retire_pr;
    logic                         recover_en;
    addr_t                        recover_pc;
    phys_reg_t [n_arch_regs-1:0]  recover_map;
    fl_idx_t                      recover_fl_head;

    // model rob slots use the dut numbering so completions can name them
    arch_reg_t                   m_ar   [rob_depth];
    phys_reg_t                   m_tnew [rob_depth];
    phys_reg_t                   m_told [rob_depth];
    logic                        m_prec [rob_depth];
    logic                        m_done [rob_depth];
    addr_t                       m_tgt  [rob_depth];
    int                          m_head;
    int                          m_tail;
    int                          m_count;
    phys_reg_t [n_arch_regs-1:0] m_map;             // committed map
    phys_reg_t [n_arch_regs-1:0] spec_map;          // rename map that supplies told
    phys_reg_t                   free_q [$];        // front is the next register out
    fl_idx_t                     m_fl_head;         // pointer moves once per allocation

    // expected values of the current cycle
    logic [retire_width-1:0]     e_en;
    int                          e_n;
    logic                        e_rec;
    addr_t                       e_pc;
    phys_reg_t [n_arch_regs-1:0] e_map;
    fl_idx_t                     e_flh;
    int                          s;

    integer seed;
    int     errors;
    int     n_full;
    int     n_recover;
    int     n_triple;

    retire_top dut (.*);

    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    task automatic halt_run(input string what);
        errors++;
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_bits(input string name, input logic [retire_width-1:0] got, exp);
        if (got !== exp)
            halt_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic check_arch(input string name, input arch_reg_t got, exp);
        if (got !== exp)
            halt_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_idx(input string name, input rob_idx_t got, exp);
        if (got !== exp)
            halt_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    task automatic check_phys(input string name, input phys_reg_t got, exp);
        if (got !== exp)
            halt_run($sformatf("Mismatch at %0t: %s got p%0d expected p%0d", $time, name, got, exp));
    endtask

    task automatic check_addr(input string name, input addr_t got, exp);
        if (got !== exp)
            halt_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic check_fl_idx(input string name, input fl_idx_t got, exp);
        if (got !== exp)
            halt_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    function automatic int rnd(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    // expected retire and recovery for the model state before the coming edge
    function automatic void model_retire(output logic [retire_width-1:0] en, output int n,
                                         output logic rec, output addr_t pc,
                                         output phys_reg_t [n_arch_regs-1:0] map,
                                         output fl_idx_t flh);
        int   slot;
        int   writers;
        logic stop;
        en      = '0;
        n       = 0;
        rec     = 1'b0;
        pc      = '0;
        map     = m_map;
        writers = 0;
        stop    = 1'b0;
        for (int k = 0; k < retire_width; k++) begin          // k = 0 is the oldest
            slot = (m_head + k) % rob_depth;
            if (!stop && k < m_count && m_done[slot]) begin
                n++;
                if (m_ar[slot] != '0) begin
                    en[retire_width-1-k] = 1'b1;
                    map[m_ar[slot]]      = m_tnew[slot];
                end
                if (m_prec[slot]) begin
                    rec  = 1'b1;
                    pc   = m_tgt[slot];
                    stop = 1'b1;                              // younger ones are squashed
                end
            end else begin
                stop = 1'b1;
            end
        end
        for (int k = n; k < m_count; k++)                     // writers still holding a tnew
            if (m_ar[(m_head + k) % rob_depth] != '0)
                writers++;
        flh = m_fl_head - fl_idx_t'(writers);
    endfunction

    // advance the model across one edge
    task automatic commit_model(input int n, input logic rec, input fl_idx_t flh);
        int slot;
        for (int k = 0; k < n; k++) begin
            slot = (m_head + k) % rob_depth;
            if (m_ar[slot] != '0) begin
                m_map[m_ar[slot]] = m_tnew[slot];
                free_q.push_back(m_told[slot]);               // old mapping is free now
            end
        end
        if (rec) begin
            for (int k = m_count - 1; k >= n; k--) begin      // youngest pushed first so the oldest ends in front
                slot = (m_head + k) % rob_depth;
                if (m_ar[slot] != '0)
                    free_q.push_front(m_tnew[slot]);
            end
            m_head    = 0;
            m_tail    = 0;
            m_count   = 0;
            m_fl_head = flh;
            spec_map  = m_map;                                // rename restarts from committed state
        end else begin
            m_head  = (m_head + n) % rob_depth;
            m_count = m_count - n;
            if (complete_en)
                m_done[complete_idx] = 1'b1;
            if (dispatch_en) begin
                slot         = m_tail;
                m_ar[slot]   = dispatch_ar;
                m_told[slot] = dispatch_told;
                m_prec[slot] = dispatch_precise;
                m_tgt[slot]  = dispatch_target;
                m_done[slot] = 1'b0;
                m_tnew[slot] = '0;
                if (dispatch_ar != '0) begin
                    m_tnew[slot]          = free_q.pop_front();
                    m_fl_head             = m_fl_head + fl_idx_t'(1);
                    spec_map[dispatch_ar] = m_tnew[slot];
                end
                m_tail  = (m_tail + 1) % rob_depth;
                m_count = m_count + 1;
            end
        end
    endtask

    // compare at each rising edge, then step the model
    always @(posedge clock) begin
        if (rst_n) begin
            model_retire(e_en, e_n, e_rec, e_pc, e_map, e_flh);
            check_bits("retire_en", retire_en, e_en);
            for (int i = 0; i < retire_width; i++) begin
                if (e_en[i]) begin
                    s = (m_head + retire_width - 1 - i) % rob_depth;
                    check_arch($sformatf("retire_ar[%0d]", i), retire_ar[i], m_ar[s]);
                    check_phys($sformatf("retire_pr[%0d]", i), retire_pr[i], m_tnew[s]);
                end
            end
            check_bits("recover_en", retire_width'(recover_en), retire_width'(e_rec));
            if (e_rec) begin
                check_addr("recover_pc", recover_pc, e_pc);
                check_fl_idx("recover_fl_head", recover_fl_head, e_flh);
                for (int r = 0; r < n_arch_regs; r++)
                    check_phys($sformatf("recover_map[%0d]", r), recover_map[r], e_map[r]);
            end
            check_bits("rob_full", retire_width'(rob_full), retire_width'(m_count == rob_depth));
            check_idx("dispatch_idx", dispatch_idx, rob_idx_t'(m_tail));
            check_phys("alloc_pr", alloc_pr, free_q[0]);
            if (m_count == rob_depth)
                n_full++;
            if (e_rec)
                n_recover++;
            if (e_n == retire_width)
                n_triple++;
            commit_model(e_n, e_rec, e_flh);
        end
    end

    // chances are in eighths
    task automatic drive_random(input int disp_chance, input int comp_chance);
        arch_reg_t ar;
        dispatch_en = 1'b0;
        complete_en = 1'b0;
        if (m_count < rob_depth && rnd(8) < disp_chance) begin
            ar               = (rnd(8) == 0) ? arch_reg_t'(0) : arch_reg_t'(rnd(n_arch_regs));
            dispatch_en      = 1'b1;
            dispatch_ar      = ar;
            dispatch_told    = spec_map[ar];
            dispatch_precise = (rnd(8) == 0);                 // mispredicted branch
            dispatch_target  = addr_t'($random(seed));
        end
        if (m_count > 0 && rnd(8) < comp_chance) begin
            complete_en  = 1'b1;
            complete_idx = rob_idx_t'(m_head + rnd(m_count));
        end
    endtask

    // complete the oldest open entry without dispatching
    task automatic drive_drain();
        dispatch_en = 1'b0;
        complete_en = 1'b0;
        for (int k = 0; k < m_count && !complete_en; k++) begin
            if (!m_done[(m_head + k) % rob_depth]) begin
                complete_en  = 1'b1;
                complete_idx = rob_idx_t'(m_head + k);
            end
        end
    endtask

    initial begin
        seed             = 51494;
        rst_n            = 1'b0;
        dispatch_en      = 1'b0;
        dispatch_ar      = '0;
        dispatch_told    = '0;
        dispatch_precise = 1'b0;
        dispatch_target  = '0;
        complete_en      = 1'b0;
        complete_idx     = '0;
        for (int r = 0; r < n_arch_regs; r++) begin
            m_map[r]    = phys_reg_t'(r);                     // identity out of reset
            spec_map[r] = phys_reg_t'(r);
        end
        for (int p = n_arch_regs; p < n_phys_regs; p++)
            free_q.push_back(phys_reg_t'(p));
        m_fl_head = '0;
        m_head    = 0;
        m_tail    = 0;
        m_count   = 0;
        repeat (8) @(posedge clock);
        @(negedge clock);
        rst_n = 1'b1;
        check_phys("alloc_pr", alloc_pr, phys_reg_t'(n_arch_regs));
        repeat (4) @(negedge clock);                          // idle cycles where nothing may retire
        for (int cyc = 0; cyc < n_cycles; cyc++) begin
            @(negedge clock);
            if ((cyc / 200) % 2 == 0)
                drive_random(7, 1);                           // fill toward full
            else
                drive_random(2, 7);                           // drain with wide retirement
        end
        @(negedge clock);
        dispatch_en = 1'b0;
        complete_en = 1'b0;
        while (m_count != 0) begin
            @(negedge clock);
            drive_drain();
        end
        repeat (2) @(negedge clock);
        check_bits("rob_full", retire_width'(rob_full), '0);
        if (n_full == 0)
            halt_run("the rob never reached full during the random run");
        if (n_recover == 0)
            halt_run("no branch recovery happened during the random run");
        if (n_triple == 0)
            halt_run("no cycle retired three entries");
        $display("recoveries %0d, full cycles %0d, three-wide retires %0d",
                 n_recover, n_full, n_triple);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    // whole run plus reset and drain margin
    initial begin
        #((n_cycles + 300) * period);
        halt_run($sformatf("timeout: the run did not finish by %0t", $time));
    end

endmodule

/* design/retire_top.sv */
// retire_top: rob, architectural map table, free list and retire stage wired together
`timescale 1ns/100ps

module retire_top import retire_pkg::*; (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          dispatch_en,
    input  arch_reg_t                     dispatch_ar,
    input  phys_reg_t                     dispatch_told,    // supplied by the rename model
    input  logic                          dispatch_precise,
    input  addr_t                         dispatch_target,
    input  logic                          complete_en,
    input  rob_idx_t                      complete_idx,
    output rob_idx_t                      dispatch_idx,
    output phys_reg_t                     alloc_pr,
    output logic                          rob_full,
    output logic [retire_width-1:0]       retire_en,
    output arch_reg_t [retire_width-1:0]  retire_ar,
    output phys_reg_t [retire_width-1:0]  retire_pr,
    output logic                          recover_en,
    output addr_t                         recover_pc,
    output phys_reg_t [n_arch_regs-1:0]   recover_map,
    output fl_idx_t                       recover_fl_head
);

    // rob head to retire stage
    logic [retire_width-1:0]       head_valid;
    logic [retire_width-1:0]       head_completed;
    logic [retire_width-1:0]       head_precise;
    arch_reg_t [retire_width-1:0]  head_ar;
    phys_reg_t [retire_width-1:0]  head_tnew;
    phys_reg_t [retire_width-1:0]  head_told;
    addr_t [retire_width-1:0]      head_target;

    phys_reg_t [n_arch_regs-1:0]   arch_map;
    phys_reg_t [retire_width-1:0]  retire_told;
    logic [1:0]                    retire_count;
    fl_idx_t                       fl_head;
    rob_cnt_t                      fl_distance;
    logic                          alloc_en;

    assign alloc_en = dispatch_en && (dispatch_ar != '0);   // r0 takes no register

    rob u_rob (
        .clock, .rst_n, .dispatch_en, .dispatch_ar,
        .dispatch_tnew(alloc_pr), .dispatch_told, .dispatch_precise, .dispatch_target,
        .complete_en, .complete_idx, .retire_count, .flush(recover_en),
        .dispatch_idx, .rob_full, .head_valid, .head_completed, .head_precise,
        .head_ar, .head_tnew, .head_told, .head_target
    );

    arch_map_table u_amt (.clock, .rst_n, .retire_en, .retire_ar, .retire_pr, .arch_map);

    freelist u_fl (
        .clock, .rst_n, .alloc_en, .retire_en, .retire_told, .recover_en,
        .recover_fl_head, .alloc_pr, .fl_head, .fl_distance
    );

    retire_stage u_retire (
        .head_valid, .head_completed, .head_precise, .head_ar, .head_tnew, .head_told,
        .head_target, .arch_map, .fl_head, .fl_distance, .retire_en, .retire_ar,
        .retire_pr, .retire_told, .retire_count, .recover_en, .recover_pc,
        .recover_map, .recover_fl_head
    );

endmodule

/* design/retire_stage.sv */
// retire_stage: in-order retire decision, recovery map, redirect target and rollback head
`timescale 1ns/100ps

module retire_stage import retire_pkg::*; (
    input  logic [retire_width-1:0]       head_valid,      // [2] is the oldest entry
    input  logic [retire_width-1:0]       head_completed,
    input  logic [retire_width-1:0]       head_precise,
    input  arch_reg_t [retire_width-1:0]  head_ar,
    input  phys_reg_t [retire_width-1:0]  head_tnew,
    input  phys_reg_t [retire_width-1:0]  head_told,
    input  addr_t [retire_width-1:0]      head_target,
    input  phys_reg_t [n_arch_regs-1:0]   arch_map,
    input  fl_idx_t                       fl_head,
    input  rob_cnt_t                      fl_distance,
    output logic [retire_width-1:0]       retire_en,       // retiring and writes a register
    output arch_reg_t [retire_width-1:0]  retire_ar,
    output phys_reg_t [retire_width-1:0]  retire_pr,
    output phys_reg_t [retire_width-1:0]  retire_told,
    output logic [1:0]                    retire_count,    // all retiring entries, r0 included
    output logic                          recover_en,
    output addr_t                         recover_pc,
    output phys_reg_t [n_arch_regs-1:0]   recover_map,
    output fl_idx_t                       recover_fl_head
);

    logic     walking;   // still inside the leading run of retirable entries
    rob_cnt_t remain;    // in-flight writers left after this cycle's retirements

    // fields go straight through, retire_en says which are real
    assign retire_ar   = head_ar;
    assign retire_pr   = head_tnew;
    assign retire_told = head_told;

    always_comb begin
        walking      = 1'b1;
        retire_en    = '0;
        retire_count = '0;
        recover_en   = 1'b0;
        recover_pc   = '0;
        recover_map  = arch_map;
        remain       = fl_distance;

        for (int i = retire_width - 1; i >= 0; i--) begin
            if (walking && head_valid[i] && head_completed[i]) begin
                retire_count = retire_count + 2'd1;
                if (head_ar[i] != '0) begin              // r0 writes are dropped
                    retire_en[i]            = 1'b1;
                    recover_map[head_ar[i]] = head_tnew[i];
                    remain                  = remain - rob_cnt_t'(1);
                end
                if (head_precise[i]) begin
                    // mispredicted branch, everything younger is squashed
                    recover_en = 1'b1;
                    recover_pc = head_target[i];
                    walking    = 1'b0;
                end
            end else begin
                walking = 1'b0;                          // in-order, a stall blocks the rest
            end
        end

        // unwind the allocations of squashed writers
        recover_fl_head = fl_head - fl_idx_t'(remain);
    end

endmodule

/* design/freelist.sv */
// freelist: ring of free physical registers with alloc, told release, distance and rollback
`timescale 1ns/100ps

module freelist import retire_pkg::*; (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic                          alloc_en,         // dispatch of a writing instruction
    input  logic [retire_width-1:0]       retire_en,        // one push per set bit
    input  phys_reg_t [retire_width-1:0]  retire_told,
    input  logic                          recover_en,
    input  fl_idx_t                       recover_fl_head,  // rollback pointer from retire
    output phys_reg_t                     alloc_pr,
    output fl_idx_t                       fl_head,
    output rob_cnt_t                      fl_distance       // allocated, not yet retired
);

    typedef logic [fl_bits:0] free_cnt_t;                   // 0..fl_depth

    phys_reg_t                  ring [fl_depth];
    fl_idx_t                    tail;                       // next push slot
    free_cnt_t                  free_cnt;                   // registers sitting in the ring
    fl_idx_t [retire_width-1:0] push_ptr;                   // slot for each retiring told
    logic [1:0]                 n_push;

    assign alloc_pr = ring[fl_head];                        // head is the next register handed out

    // pack the enabled told values at the tail, oldest first
    always_comb begin
        n_push = '0;
        for (int i = retire_width - 1; i >= 0; i--) begin
            push_ptr[i] = tail + fl_idx_t'(n_push);
            if (retire_en[i])
                n_push = n_push + 2'd1;
        end
    end

    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int i = 0; i < fl_depth; i++)
                ring[i] <= phys_reg_t'(n_arch_regs + i);   // p32..p63 are free at start
            fl_head     <= '0;
            tail        <= '0;                              // ring full, tail wrapped onto head
            fl_distance <= '0;
            free_cnt    <= free_cnt_t'(fl_depth);
        end else begin
            for (int i = 0; i < retire_width; i++) begin
                if (retire_en[i])
                    ring[push_ptr[i]] <= retire_told[i];
            end
            tail <= tail + fl_idx_t'(n_push);               // retirements still count on recovery
            if (recover_en) begin
                fl_head     <= recover_fl_head;             // hand back in-flight tnews
                fl_distance <= '0;
                free_cnt    <= free_cnt_t'(fl_depth);       // nothing left in flight
            end else begin
                fl_head     <= fl_head + fl_idx_t'(alloc_en);
                fl_distance <= fl_distance + rob_cnt_t'(alloc_en) - rob_cnt_t'(n_push);
                free_cnt    <= free_cnt - free_cnt_t'(alloc_en) + free_cnt_t'(n_push);
            end
        end
    end

    a_no_alloc_empty: assert property (@(posedge clock) disable iff (!rst_n)
        alloc_en && !recover_en |-> free_cnt != '0)
        else $error("freelist: allocation from empty ring");

    // every in-flight writer holds a rob slot
    a_distance_bound: assert property (@(posedge clock) disable iff (!rst_n)
        fl_distance <= rob_cnt_t'(rob_depth))
        else $error("freelist: distance %0d beyond rob depth", fl_distance);

endmodule

/* design/arch_map_table.sv */
// arch_map_table: architectural map table, written by up to three retirements per cycle
`timescale 1ns/100ps

module arch_map_table import retire_pkg::*; (
    input  logic                          clock,
    input  logic                          rst_n,
    input  logic [retire_width-1:0]       retire_en,   // [2] oldest, r0 never enabled
    input  arch_reg_t [retire_width-1:0]  retire_ar,
    input  phys_reg_t [retire_width-1:0]  retire_pr,   // tnew of the retiring entry
    output phys_reg_t [n_arch_regs-1:0]   arch_map
);

    // committed mapping, one physical register per arch register
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            for (int r = 0; r < n_arch_regs; r++)
                arch_map[r] <= phys_reg_t'(r);             // identity map out of reset
        end else begin
            // oldest first so the youngest write to the same ar lands last
            for (int i = retire_width - 1; i >= 0; i--) begin
                if (retire_en[i])
                    arch_map[retire_ar[i]] <= retire_pr[i];
            end
        end
    end

    // r0 is never renamed, so its mapping never moves
    a_r0_fixed: assert property (@(posedge clock) disable iff (!rst_n)
        arch_map[0] == '0)
        else $error("arch map: r0 was remapped to p%0d", arch_map[0]);

endmodule

/* design/rob.sv */
// rob: circular reorder buffer with dispatch, completion marking, 3-wide head retire, flush
`timescale 1ns/100ps

module rob import retire_pkg::*; (
    input  logic                         clock,
    input  logic                         rst_n,
    input  logic                         dispatch_en,
    input  arch_reg_t                    dispatch_ar,
    input  phys_reg_t                    dispatch_tnew,
    input  phys_reg_t                    dispatch_told,
    input  logic                         dispatch_precise,
    input  addr_t                        dispatch_target,
    input  logic                         complete_en,
    input  rob_idx_t                     complete_idx,
    input  logic [1:0]                   retire_count,   // entries leaving at the next edge
    input  logic                         flush,          // branch recovery, empties the rob
    output rob_idx_t                     dispatch_idx,
    output logic                         rob_full,
    output logic [retire_width-1:0]      head_valid,     // [2] is the oldest
    output logic [retire_width-1:0]      head_completed,
    output logic [retire_width-1:0]      head_precise,
    output arch_reg_t [retire_width-1:0] head_ar,
    output phys_reg_t [retire_width-1:0] head_tnew,
    output phys_reg_t [retire_width-1:0] head_told,
    output addr_t [retire_width-1:0]     head_target
);

    // entry payload, written once at dispatch
    arch_reg_t            slot_ar      [rob_depth];
    phys_reg_t            slot_tnew    [rob_depth];
    phys_reg_t            slot_told    [rob_depth];
    logic                 slot_precise [rob_depth];
    addr_t                slot_target  [rob_depth];
    logic [rob_depth-1:0] slot_done;                  // completed bits

    rob_idx_t                    head;                // oldest entry
    rob_idx_t                    tail;                // next free slot
    rob_cnt_t                    count;               // occupancy
    rob_idx_t [retire_width-1:0] head_slot;           // slots shown to retire
    logic                        dispatch_ok;
    rob_idx_t                    complete_ofs;        // distance of completing slot from head

    assign dispatch_ok  = dispatch_en && !flush;      // recovery drops a same-cycle dispatch
    assign dispatch_idx = tail;
    assign rob_full     = (count == rob_cnt_t'(rob_depth));
    assign complete_ofs = complete_idx - head;

    // three oldest slots, element 2 at the head
    always_comb begin
        for (int i = 0; i < retire_width; i++) begin
            head_slot[i]      = head + rob_idx_t'(retire_width - 1 - i);
            head_valid[i]     = (count > rob_cnt_t'(retire_width - 1 - i));
            head_completed[i] = slot_done[head_slot[i]];
            head_precise[i]   = slot_precise[head_slot[i]];
            head_ar[i]        = slot_ar[head_slot[i]];
            head_tnew[i]      = slot_tnew[head_slot[i]];
            head_told[i]      = slot_told[head_slot[i]];
            head_target[i]    = slot_target[head_slot[i]];
        end
    end

    // pointers, count and completed bits
    always_ff @(posedge clock) begin
        if (!rst_n) begin
            head      <= '0;
            tail      <= '0;
            count     <= '0;
            slot_done <= '0;
        end else if (flush) begin
            head      <= '0;                          // younger entries are thrown away
            tail      <= '0;
            count     <= '0;
            slot_done <= '0;
        end else begin
            head  <= head + rob_idx_t'(retire_count);
            tail  <= tail + rob_idx_t'(dispatch_ok);
            count <= count + rob_cnt_t'(dispatch_ok) - rob_cnt_t'(retire_count);
            if (dispatch_ok)
                slot_done[tail] <= 1'b0;              // new entry starts incomplete
            if (complete_en)
                slot_done[complete_idx] <= 1'b1;
        end
    end

    // payload write
    always_ff @(posedge clock) begin
        if (dispatch_ok) begin
            slot_ar[tail]      <= dispatch_ar;
            slot_tnew[tail]    <= dispatch_tnew;
            slot_told[tail]    <= dispatch_told;
            slot_precise[tail] <= dispatch_precise;
            slot_target[tail]  <= dispatch_target;
        end
    end

    // front end must stall on rob_full
    a_no_dispatch_full: assert property (@(posedge clock) disable iff (!rst_n)
        dispatch_en |-> !rob_full)
        else $error("rob: dispatch while full");

    // completion comes from execution, only for live entries
    a_complete_live: assert property (@(posedge clock) disable iff (!rst_n)
        complete_en |-> (rob_cnt_t'(complete_ofs) < count))
        else $error("rob: completion of empty slot %0d", complete_idx);

endmodule

/* design/retire_pkg.sv */
// retire package: size constants and typedefs for registers, rob tags, counts and addresses
package retire_pkg;

    // machine sizes
    localparam int n_arch_regs  = 32;   // architectural registers, r0 hardwired
    localparam int n_phys_regs  = 64;   // physical register file
    localparam int rob_depth    = 16;   // reorder buffer slots
    localparam int fl_depth     = 32;   // free list slots, n_phys_regs - n_arch_regs
    localparam int retire_width = 3;    // entries looked at per cycle
    localparam int addr_bits    = 32;   // pc width

    // derived field widths
    localparam int ar_bits  = $clog2(n_arch_regs);  // 5
    localparam int pr_bits  = $clog2(n_phys_regs);  // 6
    localparam int rob_bits = $clog2(rob_depth);    // 4
    localparam int fl_bits  = $clog2(fl_depth);     // 5

    // architectural register number
    typedef logic [ar_bits-1:0] arch_reg_t;

    // physical register number, also used for tnew and told
    typedef logic [pr_bits-1:0] phys_reg_t;

    // rob slot index, wraps naturally
    typedef logic [rob_bits-1:0] rob_idx_t;

    // occupancy count, one extra bit so a full rob is representable
    typedef logic [rob_bits:0] rob_cnt_t;

    // free list slot pointer
    typedef logic [fl_bits-1:0] fl_idx_t;

    // instruction address / redirect target
    typedef logic [addr_bits-1:0] addr_t;

endpackage
